//--- Bender.yml
package:
  name: pe_tile

sources:
  - fabric_pkg.sv
  - config_pkg.sv
  - config_if.sv
  - config_decoder.sv
  - clb.sv
  - connect_box.sv
  - switch_box.sv
  - pe_tile_top.sv
  - target: test
    files:
      - tb_pe_tile.sv

//--- clb.sv
module clb (
	input logic clk,
	input logic reset,
	config_if.clb cfg,
	input logic in0,
	input logic in1,
	output logic out
);

	import config_pkg::*;

	clb_op_t op;

	always_ff @(posedge clk) begin
		if (reset) begin
			op <= op_and;
		end else if (cfg.en_clb) begin
			op <= cfg.word.clb.op;
		end
	end

	// Operands come straight from the connection boxes
	always_comb begin
		case (op)
			op_or: begin
				out = in0 | in1;
			end
			op_xor: begin
				out = in0 ^ in1;
			end
			op_nand: begin
				out = ~(in0 & in1);
			end
			default: begin
				out = in0 & in1;
			end
		endcase
	end

	// Operation must be settled once reset has run
	assert property (@(posedge clk) disable iff (reset) !$isunknown(op))
	else
		$error("clb: operation register unknown");

endmodule

//--- config_decoder.sv
module config_decoder (
	input logic clk,
	input logic reset,
	input logic [31:0] config_addr,
	input logic [31:0] config_data,
	input config_pkg::tile_id_t tile_id,
	config_if.decoder cfg
);

	import config_pkg::*;

	tile_id_t addr_tile;
	block_id_t addr_block;
	logic tile_hit;

	assign addr_tile = config_addr[15:0];
	assign addr_block = config_addr[31:16];
	assign tile_hit = (addr_tile == tile_id);

	always_comb begin
		cfg.word = config_data;
		cfg.en_clb = 1'b0;
		cfg.en_sb = 1'b0;
		cfg.en_cb0 = 1'b0;
		cfg.en_cb1 = 1'b0;
		// Writes for other tiles or unknown blocks are dropped here
		if (tile_hit) begin
			case (addr_block)
				block_clb: cfg.en_clb = 1'b1;
				block_sb:  cfg.en_sb = 1'b1;
				block_cb0: cfg.en_cb0 = 1'b1;
				block_cb1: cfg.en_cb1 = 1'b1;
				default: begin
				end
			endcase
		end
	end

	// Only one block loads per write
	assert property (@(posedge clk) disable iff (reset)
		$onehot0({cfg.en_clb, cfg.en_sb, cfg.en_cb0, cfg.en_cb1}))
	else
		$error("config_decoder: more than one block enable high");

endmodule

//--- config_if.sv
interface config_if;

	import config_pkg::*;

	// Same data word for every block
	config_word_u word;
	logic en_clb;
	logic en_sb;
	logic en_cb0;
	logic en_cb1;

	modport decoder (
		output word,
		output en_clb,
		output en_sb,
		output en_cb0,
		output en_cb1
	);

	modport clb (
		input word,
		input en_clb
	);

	modport sb (
		input word,
		input en_sb
	);

	// Each connection box gets its own enable as a separate port
	modport cb (
		input word
	);

endinterface

//--- config_pkg.sv
package config_pkg;

	import fabric_pkg::*;

	// Low half of the configuration address
	typedef logic [15:0] tile_id_t;
	// High half of the configuration address
	typedef logic [15:0] block_id_t;

	localparam block_id_t block_clb = 16'd4;
	localparam block_id_t block_cb1 = 16'd5;
	localparam block_id_t block_cb0 = 16'd6;
	localparam block_id_t block_sb  = 16'd7;

	typedef enum logic [1:0] {
		op_and  = 2'd0,
		op_or   = 2'd1,
		op_xor  = 2'd2,
		op_nand = 2'd3
	} clb_op_t;

	typedef logic [2:0] cb_sel_t;

	typedef struct packed {
		logic [29:0] unused;
		clb_op_t op;
	} clb_word_t;

	typedef struct packed {
		logic [28:0] unused;
		cb_sel_t sel;
	} cb_word_t;

	// Field index is side * num_tracks + track
	typedef struct packed {
		logic [31-2*num_out_sides*num_tracks:0] unused;
		sb_src_t [num_out_sides*num_tracks-1:0] src;
	} sb_word_t;

	typedef union packed {
		clb_word_t clb;
		cb_word_t cb;
		sb_word_t sb;
	} config_word_u;

endpackage

//--- connect_box.sv
module connect_box (
	input logic clk,
	input logic reset,
	config_if.cb cfg,
	input logic config_en,
	input logic [7:0] tracks,
	output logic block_out
);

	import config_pkg::*;

	cb_sel_t sel;

	always_ff @(posedge clk) begin
		if (reset) begin
			sel <= '0;
		end else if (config_en) begin
			sel <= cfg.word.cb.sel;
		end
	end

	// Tracks 0 to 3 enter the tile and 4 to 7 leave it on the same side
	assign block_out = tracks[sel];

	// Known tracks must reach the logic block as a known operand
	assert property (@(posedge clk) disable iff (reset)
		!$isunknown(tracks) |-> !$isunknown(block_out))
	else
		$error("connect_box: operand unknown with all tracks known");

endmodule

//--- fabric_pkg.sv
package fabric_pkg;

	localparam int num_sides = 4;
	localparam int num_tracks = 4;
	// Side 3 has no outgoing tracks
	localparam int num_out_sides = 3;

	// One bit per track on one side
	typedef logic [num_tracks-1:0] track_vec_t;

	typedef logic [1:0] side_t;

	// The three other sides in rising order and then the PE result
	typedef enum logic [1:0] {
		src_other0 = 2'd0,
		src_other1 = 2'd1,
		src_other2 = 2'd2,
		src_pe     = 2'd3
	} sb_src_t;

	// k-th side other than s, counting upward
	function automatic side_t other_side(side_t s, logic [1:0] k);
		side_t res;
		if (k < s) begin
			res = side_t'(k);
		end else begin
			res = side_t'(k + 2'd1);
		end
		return res;
	endfunction

endpackage

//--- pe_tile_top.sv
module pe_tile_top (
	input logic clk,
	input logic reset,
	input logic [31:0] config_addr,
	input logic [31:0] config_data,
	input config_pkg::tile_id_t tile_id,
	input logic in_wire_0_0,
	input logic in_wire_0_1,
	input logic in_wire_0_2,
	input logic in_wire_0_3,
	input logic in_wire_1_0,
	input logic in_wire_1_1,
	input logic in_wire_1_2,
	input logic in_wire_1_3,
	input logic in_wire_2_0,
	input logic in_wire_2_1,
	input logic in_wire_2_2,
	input logic in_wire_2_3,
	input logic in_wire_3_0,
	input logic in_wire_3_1,
	input logic in_wire_3_2,
	input logic in_wire_3_3,
	output logic out_wire_0_0,
	output logic out_wire_0_1,
	output logic out_wire_0_2,
	output logic out_wire_0_3,
	output logic out_wire_1_0,
	output logic out_wire_1_1,
	output logic out_wire_1_2,
	output logic out_wire_1_3,
	output logic out_wire_2_0,
	output logic out_wire_2_1,
	output logic out_wire_2_2,
	output logic out_wire_2_3
);

	import fabric_pkg::*;

	track_vec_t in_side0, in_side1, in_side2, in_side3;
	track_vec_t out_side0, out_side1, out_side2;
	logic [7:0] cb0_tracks, cb1_tracks;
	logic op_0, op_1, pe_output;

	config_if cfg ();

	assign in_side0 = {in_wire_0_3, in_wire_0_2, in_wire_0_1, in_wire_0_0};
	assign in_side1 = {in_wire_1_3, in_wire_1_2, in_wire_1_1, in_wire_1_0};
	assign in_side2 = {in_wire_2_3, in_wire_2_2, in_wire_2_1, in_wire_2_0};
	assign in_side3 = {in_wire_3_3, in_wire_3_2, in_wire_3_1, in_wire_3_0};

	assign {out_wire_0_3, out_wire_0_2, out_wire_0_1, out_wire_0_0} = out_side0;
	assign {out_wire_1_3, out_wire_1_2, out_wire_1_1, out_wire_1_0} = out_side1;
	assign {out_wire_2_3, out_wire_2_2, out_wire_2_1, out_wire_2_0} = out_side2;

	// Incoming tracks in the low half, routed outgoing tracks in the high half
	assign cb0_tracks = {out_side0, in_side0};
	assign cb1_tracks = {out_side1, in_side1};

	config_decoder cfg_decoder (.clk(clk), .reset(reset), .config_addr(config_addr),
		.config_data(config_data), .tile_id(tile_id), .cfg(cfg.decoder));

	clb compute_block (.clk(clk), .reset(reset), .cfg(cfg.clb), .in0(op_0), .in1(op_1),
		.out(pe_output));

	connect_box cb0 (.clk(clk), .reset(reset), .cfg(cfg.cb), .config_en(cfg.en_cb0),
		.tracks(cb0_tracks), .block_out(op_0));

	connect_box cb1 (.clk(clk), .reset(reset), .cfg(cfg.cb), .config_en(cfg.en_cb1),
		.tracks(cb1_tracks), .block_out(op_1));

	switch_box sb (.clk(clk), .reset(reset), .cfg(cfg.sb), .in_side0(in_side0),
		.in_side1(in_side1), .in_side2(in_side2), .in_side3(in_side3),
		.pe_output(pe_output), .out_side0(out_side0), .out_side1(out_side1),
		.out_side2(out_side2));

endmodule

//--- switch_box.sv
module switch_box (
	input logic clk,
	input logic reset,
	config_if.sb cfg,
	input fabric_pkg::track_vec_t in_side0,
	input fabric_pkg::track_vec_t in_side1,
	input fabric_pkg::track_vec_t in_side2,
	input fabric_pkg::track_vec_t in_side3,
	input logic pe_output,
	output fabric_pkg::track_vec_t out_side0,
	output fabric_pkg::track_vec_t out_side1,
	output fabric_pkg::track_vec_t out_side2
);

	import fabric_pkg::*;

	localparam int num_out = num_out_sides * num_tracks;

	sb_src_t [num_out-1:0] src;
	track_vec_t side_in [num_sides];
	track_vec_t side_out [num_out_sides];

	assign side_in[0] = in_side0;
	assign side_in[1] = in_side1;
	assign side_in[2] = in_side2;
	assign side_in[3] = in_side3;

	assign out_side0 = side_out[0];
	assign out_side1 = side_out[1];
	assign out_side2 = side_out[2];

	// All twelve sources load from one write
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < num_out; i++) begin
				src[i] <= src_other0;
			end
		end else if (cfg.en_sb) begin
			src <= cfg.word.sb.src;
		end
	end

	// Same track number from another side, or the PE result
	always_comb begin
		side_t cur;
		int idx;
		for (int s = 0; s < num_out_sides; s++) begin
			cur = side_t'(s);
			for (int t = 0; t < num_tracks; t++) begin
				idx = s * num_tracks + t;
				case (src[idx])
					src_other1: begin
						side_out[s][t] = side_in[other_side(cur, 2'd1)][t];
					end
					src_other2: begin
						side_out[s][t] = side_in[other_side(cur, 2'd2)][t];
					end
					src_pe: begin
						side_out[s][t] = pe_output;
					end
					default: begin
						side_out[s][t] = side_in[other_side(cur, 2'd0)][t];
					end
				endcase
			end
		end
	end

	// Every source register holds a real value after reset
	assert property (@(posedge clk) disable iff (reset) !$isunknown(src))
	else
		$error("switch_box: source register unknown");

endmodule

//--- tb_pe_tile.sv
module tb_pe_tile;

	import fabric_pkg::*;
	import config_pkg::*;

	typedef enum logic [1:0] {row_check, row_write, row_reset} row_kind_e;

	// Tracks are indexed side * 4 + track
	typedef struct packed {
		row_kind_e kind;
		logic [31:0] addr;
		logic [31:0] data;
		logic [15:0] tracks;
	} row_t;

	localparam tile_id_t my_tile = 16'h00a5;

	logic clk;
	logic reset;
	logic [31:0] config_addr;
	logic [31:0] config_data;
	tile_id_t tile_id;
	logic [15:0] in_tracks;
	logic [11:0] out_tracks;

	row_t rows[$];
	logic [31:0] rng_state = 32'd13878;
	clb_op_t ref_op;
	cb_sel_t ref_sel0, ref_sel1;
	sb_src_t ref_src [12];

	pe_tile_top dut (
		.clk(clk), .reset(reset), .config_addr(config_addr), .config_data(config_data),
		.tile_id(tile_id),
		.in_wire_0_0(in_tracks[0]), .in_wire_0_1(in_tracks[1]), .in_wire_0_2(in_tracks[2]),
		.in_wire_0_3(in_tracks[3]), .in_wire_1_0(in_tracks[4]), .in_wire_1_1(in_tracks[5]),
		.in_wire_1_2(in_tracks[6]), .in_wire_1_3(in_tracks[7]), .in_wire_2_0(in_tracks[8]),
		.in_wire_2_1(in_tracks[9]), .in_wire_2_2(in_tracks[10]), .in_wire_2_3(in_tracks[11]),
		.in_wire_3_0(in_tracks[12]), .in_wire_3_1(in_tracks[13]),
		.in_wire_3_2(in_tracks[14]), .in_wire_3_3(in_tracks[15]),
		.out_wire_0_0(out_tracks[0]), .out_wire_0_1(out_tracks[1]),
		.out_wire_0_2(out_tracks[2]), .out_wire_0_3(out_tracks[3]),
		.out_wire_1_0(out_tracks[4]), .out_wire_1_1(out_tracks[5]),
		.out_wire_1_2(out_tracks[6]), .out_wire_1_3(out_tracks[7]),
		.out_wire_2_0(out_tracks[8]), .out_wire_2_1(out_tracks[9]),
		.out_wire_2_2(out_tracks[10]), .out_wire_2_3(out_tracks[11])
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	function automatic logic [31:0] next_random();
		rng_state ^= rng_state << 13;
		rng_state ^= rng_state >> 17;
		rng_state ^= rng_state << 5;
		return rng_state;
	endfunction

	// k-th side other than s in rising order
	function automatic int nth_other(int s, int k);
		return (k < s) ? k : k + 1;
	endfunction

	function automatic logic [31:0] sb_all(sb_src_t v);
		logic [31:0] w;
		w = '0;
		for (int i = 0; i < 12; i++) begin
			w[2*i +: 2] = v;
		end
		return w;
	endfunction

	function automatic logic [11:0] route(logic [15:0] tin, logic pe);
		logic [11:0] res;
		for (int s = 0; s < 3; s++) begin
			for (int t = 0; t < 4; t++) begin
				if (ref_src[s*4+t] == src_pe) begin
					res[s*4+t] = pe;
				end else begin
					res[s*4+t] = tin[nth_other(s, int'(ref_src[s*4+t])) * 4 + t];
				end
			end
		end
		return res;
	endfunction

	// Operands may come from routed outputs, which never depend on the PE result here
	function automatic logic [11:0] expected_outputs(logic [15:0] tin);
		logic [11:0] pre;
		logic a, b, pe;
		pre = route(tin, 1'b0);
		a = ref_sel0[2] ? pre[ref_sel0[1:0]] : tin[ref_sel0[1:0]];
		b = ref_sel1[2] ? pre[4 + ref_sel1[1:0]] : tin[4 + ref_sel1[1:0]];
		case (ref_op)
			op_or: pe = a | b;
			op_xor: pe = a ^ b;
			op_nand: pe = ~(a & b);
			default: pe = a & b;
		endcase
		return route(tin, pe);
	endfunction

	task automatic reset_model();
		ref_op = op_and;
		ref_sel0 = '0;
		ref_sel1 = '0;
		for (int i = 0; i < 12; i++) begin
			ref_src[i] = src_other0;
		end
	endtask

	task automatic apply_write(logic [31:0] addr, logic [31:0] data);
		if (addr[15:0] == my_tile) begin
			case (addr[31:16])
				block_clb: ref_op = clb_op_t'(data[1:0]);
				block_cb0: ref_sel0 = data[2:0];
				block_cb1: ref_sel1 = data[2:0];
				block_sb: begin
					for (int i = 0; i < 12; i++) begin
						ref_src[i] = sb_src_t'(data[2*i +: 2]);
					end
				end
				default: begin
				end
			endcase
		end
	endtask

	task automatic check_side(side_t side, track_vec_t got, track_vec_t exp);
		if (got !== exp) begin
			$display("FAIL time %0t side %0d got %b expected %b", $time, side, got, exp);
			$display("=== FAIL ===");
			$fatal(1, "tile output mismatch");
		end
	endtask

	task automatic add_row(row_kind_e kind, logic [15:0] blk, logic [15:0] tile,
		logic [31:0] data, logic [15:0] tracks);
		rows.push_back('{kind: kind, addr: {blk, tile}, data: data, tracks: tracks});
	endtask

	task automatic add_checks(int n);
		for (int i = 0; i < n; i++) begin
			add_row(row_check, 16'd0, my_tile, 32'd0, 16'(next_random()));
		end
	endtask

	task automatic build_table();
		logic [15:0] r;
		add_checks(6);
		for (int v = 0; v < 4; v++) begin
			add_row(row_write, block_sb, my_tile, sb_all(sb_src_t'(v)), 16'd0);
			add_checks(3);
		end
		// Track 3 of each output side carries the PE result
		add_row(row_write, block_sb, my_tile, 32'h00e4e4e4, 16'd0);
		add_row(row_write, block_cb0, my_tile, 32'd2, 16'd0);
		add_row(row_write, block_cb1, my_tile, 32'd1, 16'd0);
		for (int op = 0; op < 4; op++) begin
			add_row(row_write, block_clb, my_tile, op, 16'd0);
			for (int c = 0; c < 4; c++) begin
				r = 16'(next_random());
				r[2] = c[0];
				r[5] = c[1];
				add_row(row_check, 16'd0, my_tile, 32'd0, r);
			end
		end
		// Operands from routed outputs not driven by the PE
		add_row(row_write, block_cb0, my_tile, 32'd5, 16'd0);
		add_row(row_write, block_cb1, my_tile, 32'd6, 16'd0);
		add_row(row_write, block_clb, my_tile, op_xor, 16'd0);
		add_checks(4);
		add_row(row_write, block_sb, my_tile ^ 16'd1, sb_all(src_pe), 16'd0);
		add_row(row_write, 16'd3, my_tile, sb_all(src_pe), 16'd0);
		add_row(row_write, block_clb, 16'hffff, op_nand, 16'd0);
		add_checks(4);
		add_row(row_reset, 16'd0, my_tile, 32'd0, 16'd0);
		add_checks(4);
	endtask

	initial begin
		int waited;
		logic [11:0] exp;
		reset = 1'b1;
		config_addr = '0;
		config_data = '0;
		tile_id = my_tile;
		in_tracks = '0;
		reset_model();
		build_table();
		repeat (16) @(negedge clk);
		reset = 1'b0;
		waited = 0;
		while ($isunknown(out_tracks) && waited < 20) begin
			@(posedge clk);
			waited++;
		end
		if ($isunknown(out_tracks)) begin
			$display("Tile outputs still unknown 20 cycles after reset was released");
			$display("=== FAIL ===");
			$fatal(1, "outputs unknown after reset");
		end
		foreach (rows[i]) begin
			@(negedge clk);
			reset = (rows[i].kind == row_reset);
			config_addr = (rows[i].kind == row_write) ? rows[i].addr : {16'd0, my_tile};
			config_data = rows[i].data;
			in_tracks = rows[i].tracks;
			@(posedge clk);
			if (rows[i].kind == row_reset) begin
				reset_model();
			end else begin
				exp = expected_outputs(in_tracks);
				check_side(2'd0, out_tracks[3:0], exp[3:0]);
				check_side(2'd1, out_tracks[7:4], exp[7:4]);
				check_side(2'd2, out_tracks[11:8], exp[11:8]);
				if (rows[i].kind == row_write) begin
					apply_write(rows[i].addr, rows[i].data);
				end
			end
		end
		$display("=== PASS ===");
		$finish;
	end

endmodule

//--- verilog.f
fabric_pkg.sv
config_pkg.sv
config_if.sv
config_decoder.sv
clb.sv
connect_box.sv
switch_box.sv
pe_tile_top.sv
tb_pe_tile.sv
